//--- tb.f
+incdir+design
design/mem_pkg.sv
design/sop_tracker.sv
design/burst_gearbox.sv
design/burst_map.sv
design/mem_arbiter.sv
design/burst_mem.sv
design/mem_subsys_top.sv
bench/mem_subsys_asserts.sv
bench/mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f tb.f -o mem_subsys_sim

./obj_dir/mem_subsys_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- bench/mem_subsys_tb.sv
// Testbench for the burst memory subsystem with model memory, read data checks and timeout
`timescale 1ns/100ps
`include "mem_settings.svh"

module mem_subsys_tb;

    logic              clk;
    logic              reset_n;
    logic              rd_read;
    mem_pkg::addr_t    rd_address;
    mem_pkg::m_burst_t rd_burstcount;
    logic              rd_waitrequest;
    mem_pkg::data_t    rd_readdata;
    logic              rd_readdatavalid;
    logic              wr_write;
    mem_pkg::addr_t    wr_address;
    mem_pkg::m_burst_t wr_burstcount;
    mem_pkg::data_t    wr_writedata;
    logic              wr_waitrequest;
    logic              wr_writeresponsevalid;

    // Reference copy of the memory contents
    mem_pkg::data_t model [`MEM_DEPTH];
    // Read data still owed by the DUT, oldest beat first
    mem_pkg::data_t expect_q [$];

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int wr_bursts = 0;
    int wr_resps = 0;
    int beat_total = 0;
    int cycles = 0;

    mem_subsys_top DUT (.*);

    // Protocol checker sits inside the top level so it can see the slave channel
    bind mem_subsys_top mem_subsys_asserts protocol_checks
    (
        .clk                   (clk),
        .reset_n               (reset_n),
        .rd_read               (rd_read),
        .rd_waitrequest        (rd_waitrequest),
        .rd_burstcount         (rd_burstcount),
        .rd_readdatavalid      (rd_readdatavalid),
        .wr_write              (wr_write),
        .wr_waitrequest        (wr_waitrequest),
        .wr_burstcount         (wr_burstcount),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .s_rd_read             (s_rd_read),
        .s_rd_address          (s_rd_address),
        .s_rd_burstcount       (s_rd_burstcount),
        .s_rd_waitrequest      (s_rd_waitrequest),
        .s_wr_write            (s_wr_write),
        .s_wr_address          (s_wr_address),
        .s_wr_burstcount       (s_wr_burstcount),
        .s_wr_waitrequest      (s_wr_waitrequest),
        .s_wr_sop              (u_burst_map.s_wr_sop),
        .owner                 (u_mem_arbiter.owner),
        .mem_rd_en             (mem_rd_en),
        .mem_wr_en             (mem_wr_en)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // The limit grows with every burst issued, so a stalled DUT runs into it
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > 4 * beat_total + 200)
        begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Read data and write response monitor on the falling edge
    always @(negedge clk)
    begin : response_monitor
        mem_pkg::data_t exp;
        if (reset_n && rd_readdatavalid)
        begin
            if (expect_q.size() == 0)
            begin
                errors++;
                $display("Read data arrived at %0t with no read outstanding", $time);
            end
            else
            begin
                exp = expect_q.pop_front();
                checks++;
                assert (rd_readdata == exp)
                else
                begin
                    errors++;
                    $display("CHECK FAILED at %0t: rd_readdata expected %h, got %h",
                             $time, exp, rd_readdata);
                end
            end
        end
        if (reset_n && wr_writeresponsevalid)
            wr_resps++;
    end

    function automatic int rand_len();
        return int'($urandom_range(8, 1));
    endfunction

    // Called right after a drive on the falling edge, returns on the falling
    // edge that follows the rising edge where the beat transferred
    task automatic wait_wr_ready();
        #4;
        while (wr_waitrequest)
        begin
            @(negedge clk);
            #4;
        end
        @(negedge clk);
    endtask

    task automatic wait_rd_ready();
        #4;
        while (rd_waitrequest)
        begin
            @(negedge clk);
            #4;
        end
        @(negedge clk);
    endtask

    task automatic write_burst(input int addr, input int len);
        mem_pkg::data_t d;
        beat_total += len;
        for (int i = 0; i < len; i++)
        begin
            d = $urandom;
            wr_write = 1'b1;
            wr_address = mem_pkg::addr_t'(addr);
            wr_burstcount = mem_pkg::m_burst_t'(len);
            wr_writedata = d;
            model[addr + i] = d;
            wait_wr_ready();
        end
        wr_write = 1'b0;
        wr_bursts++;
    endtask

    task automatic read_burst(input int addr, input int len);
        beat_total += len;
        for (int i = 0; i < len; i++)
            expect_q.push_back(model[addr + i]);
        rd_read = 1'b1;
        rd_address = mem_pkg::addr_t'(addr);
        rd_burstcount = mem_pkg::m_burst_t'(len);
        wait_rd_ready();
        rd_read = 1'b0;
    endtask

    // Covers [base, limit) with back to back bursts of random length
    task automatic fill_region(input int base, input int limit);
        int addr;
        int len;
        addr = base;
        while (addr < limit)
        begin
            len = rand_len();
            if (addr + len > limit)
                len = limit - addr;
            write_burst(addr, len);
            addr += len;
        end
    endtask

    task automatic read_region(input int n, input int base, input int limit);
        int len;
        repeat (n)
        begin
            len = rand_len();
            read_burst(int'($urandom_range(limit - len, base)), len);
        end
    endtask

    // Waits until all read data and every write response are back
    task automatic drain();
        while (expect_q.size() != 0 || wr_resps < wr_bursts)
            @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    initial
    begin
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        void'($urandom(32'hcbb80d83));
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);
        tests++;
        $display("test reset_state done, %0d errors", errors);

        fill_region(0, 128);
        drain();
        tests++;
        $display("test write_fill done, %0d bursts, %0d errors", wr_bursts, errors);

        read_region(24, 0, 128);
        drain();
        tests++;
        $display("test random_read done, %0d checks, %0d errors", checks, errors);

        // Writes to the upper half race reads of the lower half
        fork
            fill_region(128, 256);
            read_region(16, 0, 128);
        join
        drain();
        tests++;
        $display("test overlap done, %0d checks, %0d errors", checks, errors);

        read_region(16, 128, 256);
        drain();
        tests++;
        $display("test upper_readback done, %0d checks, %0d errors", checks, errors);

        checks++;
        assert (wr_resps == wr_bursts)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t: wr_writeresponsevalid count expected %0d, got %0d",
                     $time, wr_bursts, wr_resps);
        end
        tests++;
        $display("test write_responses done, %0d responses, %0d errors", wr_resps, errors);

        errors += DUT.protocol_checks.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d failures", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- bench/mem_subsys_asserts.sv
// Bound assertions on handshakes, slave burst rules and arbiter ownership
`timescale 1ns/100ps

module mem_subsys_asserts
(
    input logic                clk,
    input logic                reset_n,
    input logic                rd_read,
    input logic                rd_waitrequest,
    input mem_pkg::m_burst_t   rd_burstcount,
    input logic                rd_readdatavalid,
    input logic                wr_write,
    input logic                wr_waitrequest,
    input mem_pkg::m_burst_t   wr_burstcount,
    input logic                wr_writeresponsevalid,
    input logic                s_rd_read,
    input mem_pkg::addr_t      s_rd_address,
    input mem_pkg::s_burst_t   s_rd_burstcount,
    input logic                s_rd_waitrequest,
    input logic                s_wr_write,
    input mem_pkg::addr_t      s_wr_address,
    input mem_pkg::s_burst_t   s_wr_burstcount,
    input logic                s_wr_waitrequest,
    input logic                s_wr_sop,
    input mem_pkg::mem_owner_t owner,
    input logic                mem_rd_en,
    input logic                mem_wr_en
);

    int fail_count = 0;
    // Read beats accepted on the master side and not yet returned
    int rd_pending;
    int wr_burst_count;
    int wr_resp_count;
    int wr_beats_left;
    // Memory beats of the granted slave burst, counted from the slave handshake
    int grant_beats;
    int beats_after;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_pending <= 0;
            wr_burst_count <= 0;
            wr_resp_count <= 0;
            wr_beats_left <= 0;
            grant_beats <= 0;
        end
        else
        begin
            rd_pending <= rd_pending + ((rd_read && !rd_waitrequest) ? int'(rd_burstcount) : 0)
                          - (rd_readdatavalid ? 1 : 0);
            // A master write burst counts once, on its first beat
            if (wr_write && !wr_waitrequest)
            begin
                if (wr_beats_left == 0)
                begin
                    wr_burst_count <= wr_burst_count + 1;
                    wr_beats_left <= int'(wr_burstcount) - 1;
                end
                else
                    wr_beats_left <= wr_beats_left - 1;
            end
            if (wr_writeresponsevalid)
                wr_resp_count <= wr_resp_count + 1;
            // A slave burst is granted in the cycle its request is taken
            if (s_rd_read && !s_rd_waitrequest)
                grant_beats <= int'(s_rd_burstcount);
            // The first write beat reaches the memory in the grant cycle
            else if (s_wr_write && s_wr_sop && !s_wr_waitrequest)
                grant_beats <= int'(s_wr_burstcount) - 1;
            else
                grant_beats <= beats_after;
        end
    end

    // Beats still owed once this cycle's memory beat is done
    assign beats_after = grant_beats - ((mem_rd_en || mem_wr_en) ? 1 : 0);

    reset_state: assert property (@(posedge clk) !reset_n |=>
        (owner == mem_pkg::OWNER_NONE && !rd_readdatavalid && !wr_writeresponsevalid))
    else
    begin
        fail_count++;
        $error("Outputs or arbiter owner not idle after reset");
    end

    rd_beat_count: assert property (@(posedge clk) disable iff (!reset_n)
        rd_readdatavalid |-> rd_pending > 0)
    else
    begin
        fail_count++;
        $error("More read data beats than were requested");
    end

    wr_resp_count_ok: assert property (@(posedge clk) disable iff (!reset_n)
        wr_writeresponsevalid |-> wr_resp_count < wr_burst_count)
    else
    begin
        fail_count++;
        $error("More write responses than accepted write bursts");
    end

    s_rd_rules: assert property (@(posedge clk) disable iff (!reset_n)
        s_rd_read |-> (s_rd_burstcount == 2'd1 ||
                       (s_rd_burstcount == 2'd2 && !s_rd_address[0])))
    else
    begin
        fail_count++;
        $error("Illegal or misaligned slave read burst");
    end

    s_wr_rules: assert property (@(posedge clk) disable iff (!reset_n)
        (s_wr_write && s_wr_sop) |-> (s_wr_burstcount == 2'd1 ||
                                      (s_wr_burstcount == 2'd2 && !s_wr_address[0])))
    else
    begin
        fail_count++;
        $error("Illegal or misaligned slave write burst");
    end

    owner_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (owner != mem_pkg::OWNER_NONE && beats_after > 0) |=> owner == $past(owner))
    else
    begin
        fail_count++;
        $error("Arbiter owner changed with burst beats left");
    end

endmodule

//--- design/mem_subsys_top.sv
// Top level joining the burst adapter, the arbiter and the memory
`timescale 1ns/100ps

module mem_subsys_top
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              rd_read,
    input  mem_pkg::addr_t    rd_address,
    input  mem_pkg::m_burst_t rd_burstcount,
    output logic              rd_waitrequest,
    output mem_pkg::data_t    rd_readdata,
    output logic              rd_readdatavalid,
    input  logic              wr_write,
    input  mem_pkg::addr_t    wr_address,
    input  mem_pkg::m_burst_t wr_burstcount,
    input  mem_pkg::data_t    wr_writedata,
    output logic              wr_waitrequest,
    output logic              wr_writeresponsevalid
);

    // Slave channel between adapter and arbiter
    logic s_rd_read, s_rd_waitrequest;
    mem_pkg::addr_t s_rd_address, s_wr_address;
    mem_pkg::s_burst_t s_rd_burstcount, s_wr_burstcount;
    logic s_wr_write, s_wr_user, s_wr_waitrequest;
    mem_pkg::data_t s_wr_writedata;
    logic s_wr_writeresponsevalid, s_wr_writeresponseuser;

    // Memory port
    logic mem_rd_en, mem_wr_en, mem_wr_last_user, mem_rvalid;
    mem_pkg::addr_t mem_addr;
    mem_pkg::data_t mem_wdata, mem_rdata;
    logic mem_wr_resp_valid, mem_wr_resp_user;

    burst_map #(.NATURAL_ALIGNMENT(1)) u_burst_map
    (
        .clk, .reset_n,
        .rd_read, .rd_address, .rd_burstcount, .rd_waitrequest,
        .rd_readdata, .rd_readdatavalid,
        .wr_write, .wr_address, .wr_burstcount, .wr_writedata,
        .wr_waitrequest, .wr_writeresponsevalid,
        .s_rd_read, .s_rd_address, .s_rd_burstcount, .s_rd_waitrequest,
        .s_rd_readdata(mem_rdata), .s_rd_readdatavalid(mem_rvalid),
        .s_wr_write, .s_wr_address, .s_wr_burstcount, .s_wr_writedata,
        .s_wr_user, .s_wr_waitrequest,
        .s_wr_writeresponsevalid, .s_wr_writeresponseuser
    );

    mem_arbiter u_mem_arbiter
    (
        .clk, .reset_n,
        .s_rd_read, .s_rd_address, .s_rd_burstcount, .s_rd_waitrequest,
        .s_wr_write, .s_wr_address, .s_wr_burstcount, .s_wr_writedata,
        .s_wr_user, .s_wr_waitrequest,
        .s_wr_writeresponsevalid, .s_wr_writeresponseuser,
        .mem_rd_en, .mem_wr_en, .mem_addr, .mem_wdata, .mem_wr_last_user,
        .mem_wr_resp_valid, .mem_wr_resp_user
    );

    burst_mem u_burst_mem
    (
        .clk, .reset_n,
        .mem_rd_en, .mem_wr_en, .mem_addr, .mem_wdata, .mem_wr_last_user,
        .mem_rdata, .mem_rvalid,
        .wr_resp_valid(mem_wr_resp_valid), .wr_resp_user(mem_wr_resp_user)
    );

endmodule

//--- design/burst_mem.sv
// Single-port word memory with registered reads and a write response pulse
`timescale 1ns/100ps
`include "mem_settings.svh"

module burst_mem
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           mem_rd_en,
    input  logic           mem_wr_en,
    input  mem_pkg::addr_t mem_addr,
    input  mem_pkg::data_t mem_wdata,
    input  logic           mem_wr_last_user,
    output mem_pkg::data_t mem_rdata,
    output logic           mem_rvalid,
    output logic           wr_resp_valid,
    output logic           wr_resp_user
);

    mem_pkg::data_t mem_array [`MEM_DEPTH];

    // Array and read data register
    always_ff @(posedge clk)
    begin
        if (mem_wr_en)
            mem_array[mem_addr] <= mem_wdata;
        if (mem_rd_en)
            mem_rdata <= mem_array[mem_addr];
    end

    // Read valid trails the read by one cycle, same for the write response
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mem_rvalid <= 1'b0;
            wr_resp_valid <= 1'b0;
        end
        else
        begin
            mem_rvalid <= mem_rd_en;
            wr_resp_valid <= mem_wr_en && mem_wr_last_user;
        end
    end

    // Echo of the user bit that came with the response beat
    always_ff @(posedge clk)
    begin
        if (mem_wr_en)
            wr_resp_user <= mem_wr_last_user;
    end

endmodule

//--- design/mem_arbiter.sv
// Burst-granular arbiter between the read and write slave channels
`timescale 1ns/100ps

module mem_arbiter
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              s_rd_read,
    input  mem_pkg::addr_t    s_rd_address,
    input  mem_pkg::s_burst_t s_rd_burstcount,
    output logic              s_rd_waitrequest,

    input  logic              s_wr_write,
    input  mem_pkg::addr_t    s_wr_address,
    input  mem_pkg::s_burst_t s_wr_burstcount,
    input  mem_pkg::data_t    s_wr_writedata,
    input  logic              s_wr_user,
    output logic              s_wr_waitrequest,
    output logic              s_wr_writeresponsevalid,
    output logic              s_wr_writeresponseuser,

    // Single memory port
    output logic              mem_rd_en,
    output logic              mem_wr_en,
    output mem_pkg::addr_t    mem_addr,
    output mem_pkg::data_t    mem_wdata,
    output logic              mem_wr_last_user,
    input  logic              mem_wr_resp_valid,
    input  logic              mem_wr_resp_user
);

    mem_pkg::mem_owner_t owner;
    mem_pkg::s_burst_t beats_left;
    mem_pkg::addr_t cur_addr;
    logic prefer_wr;
    logic wr_user_q;
    logic idle;
    logic grant_rd;
    logic grant_wr;
    logic wr_beat;
    logic wr_last;
    logic wr_user;

    assign idle = (owner == mem_pkg::OWNER_NONE);

    // With both channels waiting the preferred one wins, and it flips on each grant
    assign grant_rd = idle && s_rd_read && (!s_wr_write || !prefer_wr);
    assign grant_wr = idle && s_wr_write && (!s_rd_read || prefer_wr);

    // An idle channel with no request sees no waitrequest
    assign s_rd_waitrequest = !idle || (s_rd_read && !grant_rd);
    assign s_wr_waitrequest = (owner == mem_pkg::OWNER_RD) || (idle && s_wr_write && !grant_wr);

    // The first write beat goes straight to memory in the grant cycle
    assign wr_beat = grant_wr || ((owner == mem_pkg::OWNER_WR) && s_wr_write);
    assign wr_last = idle ? (s_wr_burstcount == mem_pkg::s_burst_t'(1)) :
                            (beats_left == mem_pkg::s_burst_t'(1));
    assign wr_user = idle ? s_wr_user : wr_user_q;

    // Read beats start the cycle after the request is taken
    assign mem_rd_en = (owner == mem_pkg::OWNER_RD);
    assign mem_wr_en = wr_beat;
    assign mem_addr = grant_wr ? s_wr_address : cur_addr;
    assign mem_wdata = s_wr_writedata;
    assign mem_wr_last_user = wr_beat && wr_last && wr_user;

    // Memory responses return untouched
    assign s_wr_writeresponsevalid = mem_wr_resp_valid;
    assign s_wr_writeresponseuser = mem_wr_resp_user;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            owner <= mem_pkg::OWNER_NONE;
            prefer_wr <= 1'b1;
            beats_left <= '0;
        end
        else
        begin
            case (owner)
                mem_pkg::OWNER_NONE:
                begin
                    if (grant_rd)
                    begin
                        owner <= mem_pkg::OWNER_RD;
                        beats_left <= s_rd_burstcount;
                        prefer_wr <= 1'b1;
                    end
                    else if (grant_wr)
                    begin
                        // A single-beat write is done in the grant cycle
                        if (!wr_last)
                            owner <= mem_pkg::OWNER_WR;
                        beats_left <= s_wr_burstcount - mem_pkg::s_burst_t'(1);
                        prefer_wr <= 1'b0;
                    end
                end
                mem_pkg::OWNER_RD:
                begin
                    beats_left <= beats_left - mem_pkg::s_burst_t'(1);
                    if (beats_left == mem_pkg::s_burst_t'(1))
                        owner <= mem_pkg::OWNER_NONE;
                end
                mem_pkg::OWNER_WR:
                begin
                    if (s_wr_write)
                    begin
                        beats_left <= beats_left - mem_pkg::s_burst_t'(1);
                        if (wr_last)
                            owner <= mem_pkg::OWNER_NONE;
                    end
                end
                default:
                    owner <= mem_pkg::OWNER_NONE;
            endcase
        end
    end

    // Burst address and user bit captured at grant
    always_ff @(posedge clk)
    begin
        if (grant_rd)
        begin
            cur_addr <= s_rd_address;
        end
        else if (grant_wr)
        begin
            cur_addr <= s_wr_address + mem_pkg::addr_t'(1);
            wr_user_q <= s_wr_user;
        end
        else if (mem_rd_en || wr_beat)
        begin
            cur_addr <= cur_addr + mem_pkg::addr_t'(1);
        end
    end

endmodule

//--- design/burst_map.sv
// Burst count adapter from 8-beat master bursts to 2-beat slave bursts
`timescale 1ns/100ps

module burst_map
#(
    parameter int NATURAL_ALIGNMENT = 0
)
(
    input  logic              clk,
    input  logic              reset_n,

    // Master read channel
    input  logic              rd_read,
    input  mem_pkg::addr_t    rd_address,
    input  mem_pkg::m_burst_t rd_burstcount,
    output logic              rd_waitrequest,
    output mem_pkg::data_t    rd_readdata,
    output logic              rd_readdatavalid,

    // Master write channel
    input  logic              wr_write,
    input  mem_pkg::addr_t    wr_address,
    input  mem_pkg::m_burst_t wr_burstcount,
    input  mem_pkg::data_t    wr_writedata,
    output logic              wr_waitrequest,
    output logic              wr_writeresponsevalid,

    // Slave read channel
    output logic              s_rd_read,
    output mem_pkg::addr_t    s_rd_address,
    output mem_pkg::s_burst_t s_rd_burstcount,
    input  logic              s_rd_waitrequest,
    input  mem_pkg::data_t    s_rd_readdata,
    input  logic              s_rd_readdatavalid,

    // Slave write channel
    output logic              s_wr_write,
    output mem_pkg::addr_t    s_wr_address,
    output mem_pkg::s_burst_t s_wr_burstcount,
    output mem_pkg::data_t    s_wr_writedata,
    output logic              s_wr_user,
    input  logic              s_wr_waitrequest,
    input  logic              s_wr_writeresponsevalid,
    input  logic              s_wr_writeresponseuser
);

    logic rd_next;
    logic rd_complete;
    logic wr_complete;
    logic m_wr_sop;
    logic s_wr_sop;

    // Take a new master read once the slave side is idle or is
    // accepting the last slave burst of the current request
    assign rd_next = !s_rd_waitrequest && (!s_rd_read || rd_complete);
    assign rd_waitrequest = !rd_next;

    burst_gearbox #(.NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)) rd_gearbox
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .m_new_req      (rd_next),
        .m_addr         (rd_address),
        .m_burstcount   (rd_burstcount),
        .s_accept_req   (!s_rd_waitrequest),
        .s_req_complete (rd_complete),
        .s_addr         (s_rd_address),
        .s_burstcount   (s_rd_burstcount)
    );

    // The gearbox holds address and count, only the valid is kept here
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            s_rd_read <= 1'b0;
        else if (rd_next)
            s_rd_read <= rd_read;
    end

    // Read data carries no burst information
    assign rd_readdata = s_rd_readdata;
    assign rd_readdatavalid = s_rd_readdatavalid;

    // Write beats move through one register stage in lockstep with the slave
    assign wr_waitrequest = s_wr_waitrequest;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            s_wr_write <= 1'b0;
        else if (!s_wr_waitrequest)
            s_wr_write <= wr_write;
    end

    always_ff @(posedge clk)
    begin
        if (!s_wr_waitrequest)
            s_wr_writedata <= wr_writedata;
    end

    burst_gearbox #(.NATURAL_ALIGNMENT(NATURAL_ALIGNMENT)) wr_gearbox
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .m_new_req      (wr_write && !s_wr_waitrequest && m_wr_sop),
        .m_addr         (wr_address),
        .m_burstcount   (wr_burstcount),
        .s_accept_req   (s_wr_write && !s_wr_waitrequest && s_wr_sop),
        .s_req_complete (wr_complete),
        .s_addr         (s_wr_address),
        .s_burstcount   (s_wr_burstcount)
    );

    sop_tracker #(.BURST_CNT_WIDTH($bits(mem_pkg::m_burst_t))) m_sop_tracker
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (wr_write && !wr_waitrequest),
        .burstcount (wr_burstcount),
        .sop        (m_wr_sop),
        .eop        ()
    );

    sop_tracker #(.BURST_CNT_WIDTH($bits(mem_pkg::s_burst_t))) s_sop_tracker
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (s_wr_write && !s_wr_waitrequest),
        .burstcount (s_wr_burstcount),
        .sop        (s_wr_sop),
        .eop        ()
    );

    // Tag the slave burst that finishes the master burst on its first beat
    assign s_wr_user = wr_complete && s_wr_sop;

    // Responses to the other slave bursts come back with user 0 and are dropped
    assign wr_writeresponsevalid = s_wr_writeresponsevalid && s_wr_writeresponseuser;

endmodule

//--- design/burst_gearbox.sv
// Gearbox that splits one master burst into a series of legal slave bursts
`timescale 1ns/100ps

module burst_gearbox
#(
    parameter int NATURAL_ALIGNMENT = 0
)
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               m_new_req,
    input  mem_pkg::addr_t     m_addr,
    input  mem_pkg::m_burst_t  m_burstcount,
    input  logic               s_accept_req,
    output logic               s_req_complete,
    output mem_pkg::addr_t     s_addr,
    output mem_pkg::s_burst_t  s_burstcount
);

    // Largest burst the slave side takes
    localparam int S_MAX = 1 << ($bits(mem_pkg::s_burst_t) - 1);

    // Beats of the master request not yet handed to the slave
    mem_pkg::m_burst_t remaining;
    mem_pkg::addr_t next_addr;
    mem_pkg::m_burst_t burst_len;

    always_comb
    begin
        if (NATURAL_ALIGNMENT != 0)
        begin
            // Grow through the powers of two while the burst still fits the
            // remaining beats and the address stays on its own boundary
            burst_len = (remaining == '0) ? '0 : mem_pkg::m_burst_t'(1);
            for (int p = 2; p <= S_MAX; p = p * 2)
            begin
                if ((p <= int'(remaining)) && ((next_addr & mem_pkg::addr_t'(p - 1)) == '0))
                    burst_len = mem_pkg::m_burst_t'(p);
            end
        end
        else
        begin
            burst_len = (remaining > mem_pkg::m_burst_t'(S_MAX)) ?
                        mem_pkg::m_burst_t'(S_MAX) : remaining;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining <= '0;
        end
        else if (m_new_req)
        begin
            // A new master request replaces whatever just finished
            remaining <= m_burstcount;
        end
        else if (s_accept_req)
        begin
            remaining <= remaining - burst_len;
        end
    end

    // Start address of the next slave burst, stepped by each accepted burst
    always_ff @(posedge clk)
    begin
        if (m_new_req)
            next_addr <= m_addr;
        else if (s_accept_req)
            next_addr <= next_addr + mem_pkg::addr_t'(burst_len);
    end

    assign s_addr = next_addr;
    assign s_burstcount = mem_pkg::s_burst_t'(burst_len);
    // The slave burst that uses up every remaining beat ends the master request
    assign s_req_complete = (remaining == burst_len);

endmodule

//--- design/sop_tracker.sv
// Start-of-packet and end-of-packet tracker for a stream of burst beats
`timescale 1ns/100ps

module sop_tracker
#(
    parameter int BURST_CNT_WIDTH = 4
)
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       flit_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop,
    output logic                       eop
);

    // Beats still to come in the burst that is in progress
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            sop <= 1'b1;
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            if (sop)
            begin
                // First beat, so burstcount is meaningful and loads the counter
                beats_left <= burstcount - BURST_CNT_WIDTH'(1);
                sop <= (burstcount == BURST_CNT_WIDTH'(1));
            end
            else
            begin
                beats_left <= beats_left - BURST_CNT_WIDTH'(1);
                sop <= (beats_left == BURST_CNT_WIDTH'(1));
            end
        end
    end

    // A single-beat burst is its own last beat
    assign eop = sop ? (burstcount == BURST_CNT_WIDTH'(1)) : (beats_left == BURST_CNT_WIDTH'(1));

endmodule

//--- design/mem_pkg.sv
// Shared vector types and the memory arbiter owner enum
`include "mem_settings.svh"

package mem_pkg;

    // Beat address and data word
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_DATA_WIDTH-1:0] data_t;

    // Burst count fields on the master and slave sides of the adapter
    typedef logic [`MASTER_BURST_WIDTH-1:0] m_burst_t;
    typedef logic [`SLAVE_BURST_WIDTH-1:0] s_burst_t;

    // Which slave channel currently holds the memory port
    typedef enum logic [1:0]
    {
        OWNER_NONE,
        OWNER_RD,
        OWNER_WR
    } mem_owner_t;

endpackage

//--- design/mem_settings.svh
// Width and depth macros for the burst memory subsystem
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Beat address width, one address per data word
`define MEM_ADDR_WIDTH 8

// Data word width
`define MEM_DATA_WIDTH 32

// Master burst count field, legal master bursts are 1 to 8
`define MASTER_BURST_WIDTH 4

// Slave burst count field, legal slave bursts are 1 to 2
`define SLAVE_BURST_WIDTH 2

// Number of words in the on-chip memory
`define MEM_DEPTH 256

`endif
